// File: source/lb_pkg.sv
`default_nettype none

package lb_pkg;

  localparam int PIX_W = 8;
  localparam int SUM_W = 10; // Three 8-bit pixels need two more bits

  typedef logic [PIX_W-1:0] pix_t;

  // One line store entry, the two rows above the current one
  typedef struct packed {
    pix_t prev1; // Row r-1
    pix_t prev2; // Row r-2
  } row_pair_t;

  typedef struct packed {
    logic valid;
    pix_t data;
    logic eol;
    logic eof; // Only together with eol
  } pix_in_t;

  typedef struct packed {
    logic             valid;
    logic [SUM_W-1:0] sum;
    logic             sol;
    logic             eol;
    logic             eof;
  } win_out_t;

  // Handoff from the row controller to the adder, one cycle after the input
  typedef struct packed {
    logic      emit;
    pix_t      pix;
    row_pair_t pair;
    logic      sol;
    logic      eol;
    logic      eof;
  } stage_t;

  typedef enum logic [2:0] {
    ST_IDLE   = 3'b000,
    ST_FILL1  = 3'b001,
    ST_FILL2  = 3'b010,
    ST_STREAM = 3'b011,
    ST_DONE   = 3'b100
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: source/line_store.sv
`timescale 1ns/100ps
`default_nettype none

module line_store #(
  parameter int DEPTH = 128
) (
  input  wire logic                     clk,
  input  wire logic [$clog2(DEPTH)-1:0] i_rd_addr,
  input  wire logic                     i_wr_en,
  input  wire logic [$clog2(DEPTH)-1:0] i_wr_addr,
  input  wire lb_pkg::row_pair_t        i_wr_data,
  output lb_pkg::row_pair_t             o_rd_data
);

  localparam int AW = $clog2(DEPTH);

  lb_pkg::row_pair_t mem [DEPTH];

  logic [AW-1:0] rd_addr;
  logic [AW-1:0] wr_addr;

  assign rd_addr = i_rd_addr;
  assign wr_addr = i_wr_addr;

  // Every entry is written during the fill rows before it is read
  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      mem[wr_addr] <= i_wr_data;
    end
  end

  // Read every cycle; a read of the address being written sees the old entry
  always_ff @(posedge clk) begin
    o_rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// File: source/row_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module row_ctrl #(
  parameter int DEPTH = 128
) (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire lb_pkg::pix_in_t          i_pix,
  output logic [$clog2(DEPTH)-1:0]      o_rd_addr,
  output logic                          o_wr_en,
  output logic [$clog2(DEPTH)-1:0]      o_wr_addr,
  output lb_pkg::row_pair_t             o_wr_data,
  input  wire lb_pkg::row_pair_t        i_rd_data,
  output lb_pkg::stage_t                o_stage
);

  localparam int AW = $clog2(DEPTH);

  lb_pkg::ctrl_state_t state_q;
  lb_pkg::ctrl_state_t state_d;

  logic [AW-1:0] col_q;
  logic [AW-1:0] col_cur;
  logic          emit_now;

  // Cycle 1 copy of the input pixel
  logic          valid_d;
  logic          emit_d;
  lb_pkg::pix_t  pix_d;
  logic [AW-1:0] col_d;
  logic          eol_d;
  logic          eof_d;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= lb_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      lb_pkg::ST_IDLE, lb_pkg::ST_DONE: begin
        // A pixel here opens a new frame, even straight out of ST_DONE
        if (i_pix.valid) begin
          if (i_pix.eof) begin
            state_d = lb_pkg::ST_DONE;
          end else if (i_pix.eol) begin
            state_d = lb_pkg::ST_FILL2; // One-pixel line already ends row 0
          end else begin
            state_d = lb_pkg::ST_FILL1;
          end
        end else begin
          state_d = lb_pkg::ST_IDLE;
        end
      end
      lb_pkg::ST_FILL1: begin
        if (i_pix.valid && i_pix.eof) begin
          state_d = lb_pkg::ST_DONE;
        end else if (i_pix.valid && i_pix.eol) begin
          state_d = lb_pkg::ST_FILL2;
        end
      end
      lb_pkg::ST_FILL2: begin
        if (i_pix.valid && i_pix.eof) begin
          state_d = lb_pkg::ST_DONE;
        end else if (i_pix.valid && i_pix.eol) begin
          state_d = lb_pkg::ST_STREAM;
        end
      end
      lb_pkg::ST_STREAM: begin
        if (i_pix.valid && i_pix.eof) begin
          state_d = lb_pkg::ST_DONE;
        end
      end
      default: begin
        state_d = lb_pkg::ST_IDLE;
      end
    endcase
  end

  // ST_DONE clears the column, but a pixel arriving then still sits at column 0
  assign col_cur = (state_q == lb_pkg::ST_DONE) ? '0 : col_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_q <= '0;
    end else if (i_pix.valid) begin
      col_q <= i_pix.eol ? '0 : col_cur + 1'b1;
    end else if (state_q == lb_pkg::ST_DONE) begin
      col_q <= '0;
    end
  end

  // Only rows seen in the streaming state have two rows above them
  assign emit_now = i_pix.valid && (state_q == lb_pkg::ST_STREAM);

  assign o_rd_addr = col_cur; // Cycle 0 read of the pair above this column

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_d <= 1'b0;
      emit_d  <= 1'b0;
    end else begin
      valid_d <= i_pix.valid;
      emit_d  <= emit_now;
    end
  end

  always_ff @(posedge clk) begin
    if (i_pix.valid) begin
      pix_d <= i_pix.data;
      col_d <= col_cur;
      eol_d <= i_pix.eol;
      eof_d <= i_pix.eof;
    end
  end

  // Cycle 1 write back, the rows shift down one slot in the pair
  assign o_wr_en         = valid_d;
  assign o_wr_addr       = col_d;
  assign o_wr_data.prev1 = pix_d;
  assign o_wr_data.prev2 = i_rd_data.prev1;

  always_comb begin
    o_stage.emit = emit_d;
    o_stage.pix  = pix_d;
    o_stage.pair = i_rd_data;
    o_stage.sol  = (col_d == '0);
    o_stage.eol  = eol_d;
    o_stage.eof  = eof_d;
  end

endmodule

`default_nettype wire

// File: source/vsum_stage.sv
`timescale 1ns/100ps
`default_nettype none

module vsum_stage (
  input  wire logic           clk,
  input  wire logic           rst_n,
  input  wire lb_pkg::stage_t i_stage,
  output lb_pkg::win_out_t    o_win
);

  logic [lb_pkg::SUM_W-1:0] sum;

  logic                     valid_q;
  logic [lb_pkg::SUM_W-1:0] sum_q;
  logic                     sol_q;
  logic                     eol_q;
  logic                     eof_q;

  // Zero extend each term before adding so no carry is lost
  always_comb begin
    sum = lb_pkg::SUM_W'(i_stage.pix)
        + lb_pkg::SUM_W'(i_stage.pair.prev1)
        + lb_pkg::SUM_W'(i_stage.pair.prev2);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= i_stage.emit;
    end
  end

  always_ff @(posedge clk) begin
    sum_q <= sum;
    sol_q <= i_stage.emit & i_stage.sol; // Flags stay low on idle cycles
    eol_q <= i_stage.emit & i_stage.eol;
    eof_q <= i_stage.emit & i_stage.eof;
  end

  always_comb begin
    o_win.valid = valid_q;
    o_win.sum   = sum_q;
    o_win.sol   = sol_q;
    o_win.eol   = eol_q;
    o_win.eof   = eof_q;
  end

endmodule

`default_nettype wire

// File: source/vwindow_top.sv
`timescale 1ns/100ps
`default_nettype none

module vwindow_top #(
  parameter int LINE_DEPTH = 128
) (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire lb_pkg::pix_in_t i_pix,
  output lb_pkg::win_out_t     o_win
);

  localparam int ADDR_W = $clog2(LINE_DEPTH);

  logic [ADDR_W-1:0] rd_addr;
  logic              wr_en;
  logic [ADDR_W-1:0] wr_addr;
  lb_pkg::row_pair_t wr_data;
  lb_pkg::row_pair_t rd_data;
  lb_pkg::stage_t    stage;

  // Cycle 0 to 1, frame tracking and line store access
  row_ctrl #(
    .DEPTH     (LINE_DEPTH)
  ) u_row_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_pix     (i_pix),
    .o_rd_addr (rd_addr),
    .o_wr_en   (wr_en),
    .o_wr_addr (wr_addr),
    .o_wr_data (wr_data),
    .i_rd_data (rd_data),
    .o_stage   (stage)
  );

  line_store #(
    .DEPTH     (LINE_DEPTH)
  ) u_line_store (
    .clk       (clk),
    .i_rd_addr (rd_addr),
    .i_wr_en   (wr_en),
    .i_wr_addr (wr_addr),
    .i_wr_data (wr_data),
    .o_rd_data (rd_data)
  );

  // Cycle 1 to 2, the registered vertical sum
  vsum_stage u_vsum_stage (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_stage (stage),
    .o_win   (o_win)
  );

endmodule

`default_nettype wire

// File: test/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam int DIR_ROWS = 4;
localparam int DIR_COLS = 5;

typedef struct packed {
  lb_pkg::pix_t             pix;
  logic [3:0]               idle;
  logic [lb_pkg::SUM_W-1:0] sum;
} vec_t;

// Columns are the pixel, the idle cycles that follow it, and the sum expected for it
// The two fill rows have no output, so their sum column holds zero
localparam vec_t DIR_TABLE [DIR_ROWS*DIR_COLS] = '{
  '{8'h0A, 4'd0, 10'h000}, '{8'h14, 4'd0, 10'h000}, '{8'h1E, 4'd2, 10'h000},
  '{8'h28, 4'd0, 10'h000}, '{8'h32, 4'd1, 10'h000},
  '{8'hFF, 4'd0, 10'h000}, '{8'h01, 4'd1, 10'h000}, '{8'h80, 4'd0, 10'h000},
  '{8'h7F, 4'd0, 10'h000}, '{8'h05, 4'd0, 10'h000},
  '{8'hFF, 4'd1, 10'h208}, '{8'hFE, 4'd0, 10'h113}, '{8'h80, 4'd0, 10'h11E},
  '{8'h81, 4'd3, 10'h128}, '{8'h06, 4'd2, 10'h03D},
  '{8'hFF, 4'd0, 10'h2FD}, '{8'hFF, 4'd0, 10'h1FE}, '{8'h33, 4'd1, 10'h133},
  '{8'hC8, 4'd0, 10'h1C8}, '{8'h07, 4'd0, 10'h012} // No gap, the next frame follows eof
};

`endif

// File: test/tb_vwindow.sv
`timescale 1ns/100ps
`default_nettype none

module tb_vwindow;

  `include "tb_vectors.svh"

  localparam int LINE_DEPTH  = 8;
  localparam int RND_ROWS    = 5;
  localparam int RND_COLS    = 7;
  localparam int DRAIN_LIMIT = 40;

  typedef struct packed {
    int               tag;  // Cycle in which the output is due
    int               test;
    logic             last; // Final output of its test
    lb_pkg::win_out_t win;
  } exp_t;

  logic             clk;
  logic             rst_n;
  lb_pkg::pix_in_t  i_pix;
  lb_pkg::win_out_t o_win;

  int           cyc;
  int           cur_test;
  int           errors;
  int           test_errs [2];
  int           test_outs [2];
  exp_t         exp_q [$];
  lb_pkg::pix_t frame [8][8]; // Rows of the random frame as they were sent

  vwindow_top #(
    .LINE_DEPTH (LINE_DEPTH)
  ) u_vwindow_top (
    .clk   (clk),
    .rst_n (rst_n),
    .i_pix (i_pix),
    .o_win (o_win)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  function automatic logic [lb_pkg::SUM_W-1:0] column_sum(input int row, input int col);
    return {2'b00, frame[row][col]} + {2'b00, frame[row-1][col]} + {2'b00, frame[row-2][col]};
  endfunction

  task automatic record_error(input int test);
    errors++;
    test_errs[test]++;
  endtask

  task automatic report_test(input int test);
    $display("%s: %0d outputs checked, %0d errors",
             (test == 0) ? "Directed frame" : "Random frame", test_outs[test], test_errs[test]);
  endtask

  task automatic check_win(input lb_pkg::win_out_t exp, input lb_pkg::win_out_t got,
                           input int test);
    test_outs[test]++;
    if (got !== exp) begin
      $write("Mismatch o_win in cycle %0d: expected valid=%h sum=%h sol=%h eol=%h eof=%h",
             cyc, exp.valid, exp.sum, exp.sol, exp.eol, exp.eof);
      $display(", got valid=%h sum=%h sol=%h eol=%h eof=%h",
               got.valid, got.sum, got.sol, got.eol, got.eof);
      record_error(test);
    end
  endtask

  // Drives one pixel, then valid low for the idle cycles, and queues the result it should give
  task automatic send_pixel(input lb_pkg::pix_t pix, input int row, input int col,
                            input int rows, input int cols, input int idle,
                            input logic [lb_pkg::SUM_W-1:0] exp_sum);
    exp_t e;
    @(posedge clk);
    i_pix.valid <= 1'b1;
    i_pix.data  <= pix;
    i_pix.eol   <= (col == cols - 1);
    i_pix.eof   <= (col == cols - 1) && (row == rows - 1);
    if (row >= 2) begin
      e.tag       = cyc + 3; // DUT sees the pixel in cycle cyc + 1
      e.test      = cur_test;
      e.last      = (col == cols - 1) && (row == rows - 1);
      e.win.valid = 1'b1;
      e.win.sum   = exp_sum;
      e.win.sol   = (col == 0);
      e.win.eol   = (col == cols - 1);
      e.win.eof   = e.last;
      exp_q.push_back(e);
    end
    repeat (idle) begin
      @(posedge clk);
      i_pix <= '0;
    end
  endtask

  // Sampled on the falling edge while o_win is stable
  always @(negedge clk) begin : monitor
    exp_t e;
    if (rst_n) begin
      if (exp_q.size() > 0 && exp_q[0].tag < cyc) begin
        e = exp_q.pop_front();
        $display("Output due in cycle %0d did not arrive", e.tag);
        record_error(e.test);
        if (e.last) begin
          report_test(e.test);
        end
      end
      if (o_win.valid === 1'b1 && exp_q.size() > 0 && exp_q[0].tag == cyc) begin
        e = exp_q.pop_front();
        check_win(e.win, o_win, e.test);
        if (e.last) begin
          report_test(e.test);
        end
      end else if (o_win.valid !== 1'b0) begin
        $display("Output appeared in cycle %0d where none was expected", cyc);
        record_error(cur_test);
      end
    end
  end

  initial begin
    int           wait_cnt;
    lb_pkg::pix_t pix;
    void'($urandom(32'h6e93));
    clk      = 1'b0;
    rst_n    = 1'b0;
    i_pix    = '0;
    cyc      = 0;
    cur_test = 0;
    errors   = 0;
    test_errs = '{0, 0};
    test_outs = '{0, 0};
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (o_win.valid !== 1'b0) begin
      $display("o_win.valid is not low after reset");
      record_error(0);
    end

    for (int i = 0; i < DIR_ROWS * DIR_COLS; i++) begin
      send_pixel(DIR_TABLE[i].pix, i / DIR_COLS, i % DIR_COLS, DIR_ROWS, DIR_COLS,
                 DIR_TABLE[i].idle, DIR_TABLE[i].sum);
    end

    // Starts while the DUT is still in its done state
    cur_test = 1;
    for (int r = 0; r < RND_ROWS; r++) begin
      for (int c = 0; c < RND_COLS; c++) begin
        pix = lb_pkg::pix_t'($urandom);
        frame[r][c] = pix;
        send_pixel(pix, r, c, RND_ROWS, RND_COLS, $urandom % 3,
                   (r >= 2) ? column_sum(r, c) : '0);
      end
    end
    @(posedge clk);
    i_pix <= '0;

    wait_cnt = 0;
    while (exp_q.size() > 0 && wait_cnt < DRAIN_LIMIT) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (exp_q.size() > 0) begin
      $display("Timed out, %0d expected outputs did not arrive", exp_q.size());
      errors++;
    end

    $display("Summary: %0d outputs checked, %0d errors", test_outs[0] + test_outs[1], errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+test
source/lb_pkg.sv
source/line_store.sv
source/row_ctrl.sv
source/vsum_stage.sv
source/vwindow_top.sv
test/tb_vwindow.sv

// File: Bender.yml
package:
  name: vwindow

sources:
  - files:
      - source/lb_pkg.sv
      - source/line_store.sv
      - source/row_ctrl.sv
      - source/vsum_stage.sv
      - source/vwindow_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_vwindow.sv
